/* common/execPkg.sv */
package execPkg;

    localparam int DataWidth    = 32;
    localparam int ImmWidth     = 16;
    localparam int RegAddrWidth = 4;

    typedef logic [DataWidth-1:0]        dataT;
    typedef logic signed [ImmWidth-1:0]  immT;
    typedef logic [RegAddrWidth-1:0]     regAddrT;

    typedef enum logic [1:0] {
        ClassImm    = 2'b00,
        ClassReg    = 2'b01,
        ClassMem    = 2'b10,
        ClassBranch = 2'b11
    } opClassE;

    // Upper bit marks the flag-setting variants
    typedef enum logic [3:0] {
        OpNone  = 4'b0000,
        OpAdd   = 4'b0001,
        OpSub   = 4'b0010,
        OpAnd   = 4'b0011,
        OpOr    = 4'b0100,
        OpXor   = 4'b0101,
        OpNot   = 4'b0110,
        OpNone2 = 4'b1000,
        OpAdds  = 4'b1001,
        OpSubs  = 4'b1010,
        OpAnds  = 4'b1011,
        OpOrs   = 4'b1100,
        OpXors  = 4'b1101
    } aluOpE;

    typedef enum logic [2:0] {
        MovImm   = 3'b000,
        MovTop   = 3'b001,
        MovClr   = 3'b010,
        MovSet   = 3'b011,
        MovLsl   = 3'b100,
        MovLsr   = 3'b101,
        MovFlags = 3'b110
    } movOpE;

    typedef struct packed {
        logic [1:0] rsvd;
        logic       store;                  // 1 store, 0 load
    } memFuncT;

    // Function field, move class vs memory class
    typedef union packed {
        movOpE   mov;
        memFuncT mem;
    } funcU;

    typedef enum logic [3:0] {
        Eq = 4'd0, Ne = 4'd1, Hs = 4'd2, Lo = 4'd3,
        Mi = 4'd4, Pl = 4'd5, Vs = 4'd6, Vc = 4'd7,
        Hi = 4'd8, Ls = 4'd9, Ge = 4'd10, Lt = 4'd11,
        Gt = 4'd12, Le = 4'd13
    } condE;

    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } flagsT;

    typedef struct packed {
        opClassE opClass;
        logic    special;                   // Imm class: 0 move, 1 ALU
        aluOpE   aluOp;
        funcU    func;
        condE    cond;
        immT     imm;
        regAddrT destReg;
        regAddrT srcFirst;
        regAddrT srcSec;
    } execCtrlT;

    typedef struct packed {
        regAddrT dest;
        regAddrT first;
        regAddrT sec;
    } regReadT;

    typedef struct packed {
        dataT dest;
        dataT first;
        dataT sec;
    } regDataT;

    // Write address is taken from regReadT.dest
    typedef struct packed {
        logic en;
        dataT data;
    } regWriteT;

    typedef struct packed {
        dataT addr;
        dataT wdata;
        logic write;
        logic read;
    } memReqT;

    typedef struct packed {
        logic aluEn;
        logic useImm;
        logic moveEn;
        logic loadEn;
        logic storeEn;
        logic branchEn;
    } unitSelT;

    function automatic dataT signExt(input immT imm);
        return {{(DataWidth - ImmWidth){imm[ImmWidth-1]}}, imm};
    endfunction

endpackage

/* hw/execControl.sv */
module execControl
    import execPkg::*;
(
    input  execCtrlT ctrl,
    input  regDataT  regData,
    input  dataT     memDataIn,
    input  dataT     aluResult,
    input  dataT     moveResult,
    input  logic     aluWrite,
    input  logic     moveWrite,
    output unitSelT  unitSel,
    output regReadT  regRd,
    output regWriteT regWr,
    output memReqT   memReq
);

    logic memAccess;
    dataT effAddr;

    // Only place where class and special bit are looked at
    always_comb begin : decodeClass
        unitSel = '0;
        case (ctrl.opClass)
            ClassImm: begin
                if (ctrl.special) begin
                    unitSel.aluEn  = 1'b1;
                    unitSel.useImm = 1'b1;
                end else begin
                    unitSel.moveEn = 1'b1;
                end
            end
            ClassReg: begin
                unitSel.aluEn = 1'b1;
            end
            ClassMem: begin
                if (ctrl.func.mem.store) begin
                    unitSel.storeEn = 1'b1;
                end else begin
                    unitSel.loadEn = 1'b1;
                end
            end
            default: begin
                unitSel.branchEn = 1'b1;
            end
        endcase
    end

    assign memAccess = unitSel.loadEn | unitSel.storeEn;

    // Base register plus sign-extended offset
    assign effAddr = regData.first + signExt(ctrl.imm);

    // Request only the ports the operation actually reads.
    // dest is always requested when there is a write-back,
    // since it doubles as the write address.
    always_comb begin : readPorts
        regRd = '0;
        if (unitSel.aluEn && aluWrite) begin
            regRd.dest  = ctrl.destReg;
            regRd.first = ctrl.srcFirst;
            if (!unitSel.useImm && ctrl.aluOp != OpNot) begin
                regRd.sec = ctrl.srcSec;
            end
        end else if (unitSel.moveEn && moveWrite) begin
            regRd.dest = ctrl.destReg;
            if (ctrl.func.mov inside {MovLsl, MovLsr}) begin
                regRd.first = ctrl.srcFirst;   // Shift source
            end
        end else if (memAccess) begin
            regRd.dest  = ctrl.destReg;        // Store data or load target
            regRd.first = ctrl.srcFirst;       // Base
        end
    end

    always_comb begin : memRequest
        memReq       = '0;
        memReq.write = unitSel.storeEn;
        memReq.read  = unitSel.loadEn;
        if (memAccess) begin
            memReq.addr = effAddr;
        end
        if (unitSel.storeEn) begin
            memReq.wdata = regData.dest;
        end
    end

    // Result of the enabled unit, gated by its write flag
    always_comb begin : writeBack
        regWr = '0;
        if (unitSel.aluEn) begin
            regWr.en   = aluWrite;
            regWr.data = aluResult;
        end else if (unitSel.moveEn) begin
            regWr.en   = moveWrite;
            regWr.data = moveResult;
        end else if (unitSel.loadEn) begin
            regWr.en   = 1'b1;
            regWr.data = memDataIn;            // Memory answers in the same cycle
        end
    end

endmodule

/* alu/aluUnit.sv */
module aluUnit
    import execPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  execCtrlT ctrl,
    input  regDataT  regData,
    input  unitSelT  unitSel,
    output dataT     aluResult,
    output logic     aluWrite,
    output flagsT    flags
);

    localparam int Msb = DataWidth - 1;

    dataT               opA;
    dataT               opB;
    logic [DataWidth:0] sum;
    logic [DataWidth:0] diff;
    logic               resNeg;
    logic               resZero;
    flagsT              flagsReg;
    flagsT              flagsNext;

    assign opA = regData.first;
    assign opB = unitSel.useImm ? signExt(ctrl.imm) : regData.sec;

    // Extra top bit carries out / borrows
    assign sum  = {1'b0, opA} + {1'b0, opB};
    assign diff = {1'b0, opA} - {1'b0, opB};

    always_comb begin : resultMux
        aluWrite = 1'b1;
        case (ctrl.aluOp)
            OpAdd, OpAdds: aluResult = sum[Msb:0];
            OpSub, OpSubs: aluResult = diff[Msb:0];
            OpAnd, OpAnds: aluResult = opA & opB;
            OpOr, OpOrs:   aluResult = opA | opB;
            OpXor, OpXors: aluResult = opA ^ opB;
            OpNot:         aluResult = ~opA;
            default: begin                       // OpNone, OpNone2, unused codes
                aluResult = '0;
                aluWrite  = 1'b0;
            end
        endcase
    end

    assign resNeg  = aluResult[Msb];
    assign resZero = (aluResult == '0);

    always_comb begin : flagUpdate
        flagsNext = flagsReg;
        if (unitSel.aluEn) begin
            case (ctrl.aluOp)
                OpAdds: begin
                    flagsNext.n = resNeg;
                    flagsNext.z = resZero;
                    flagsNext.c = sum[DataWidth];
                    // Same operand signs, result sign differs
                    flagsNext.v = ~(opA[Msb] ^ opB[Msb]) & (opA[Msb] ^ resNeg);
                end
                OpSubs: begin
                    flagsNext.n = resNeg;
                    flagsNext.z = resZero;
                    flagsNext.c = ~diff[DataWidth];  // Not borrow
                    flagsNext.v = (opA[Msb] ^ opB[Msb]) & (opA[Msb] ^ resNeg);
                end
                OpAnds, OpOrs, OpXors: begin
                    flagsNext.n = resNeg;            // C and V kept
                    flagsNext.z = resZero;
                end
                default: begin
                    flagsNext = flagsReg;
                end
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flagsReg <= '0;
        end else begin
            flagsReg <= flagsNext;
        end
    end

    assign flags = flagsReg;

endmodule

/* hw/moveUnit.sv */
module moveUnit
    import execPkg::*;
(
    input  execCtrlT ctrl,
    input  regDataT  regData,
    input  flagsT    flags,
    output dataT     moveResult,
    output logic     moveWrite
);

    localparam int HalfWidth = DataWidth / 2;

    dataT immZext;
    dataT shiftAmt;

    assign immZext  = {{(DataWidth - ImmWidth){1'b0}}, ctrl.imm};
    assign shiftAmt = immZext;                  // Shift count is unsigned

    always_comb begin : moveMux
        moveWrite = 1'b1;
        case (ctrl.func.mov)
            MovImm: begin
                moveResult = immZext;
            end
            MovTop: begin
                // New upper half, old low half of dest
                moveResult = {ctrl.imm, regData.dest[HalfWidth-1:0]};
            end
            MovClr: begin
                moveResult = '0;
            end
            MovSet: begin
                moveResult = '1;
            end
            MovLsl: begin
                moveResult = regData.first << shiftAmt;
            end
            MovLsr: begin
                moveResult = regData.first >> shiftAmt;
            end
            MovFlags: begin
                moveResult = {20'b0, regData.dest[31:24], flags};
            end
            default: begin                      // Code 111 unused
                moveResult = '0;
                moveWrite  = 1'b0;
            end
        endcase
    end

endmodule

/* hw/branchCond.sv */
module branchCond
    import execPkg::*;
(
    input  condE  cond,
    input  logic  branchEn,
    input  flagsT flags,
    output logic  branchTaken
);

    logic baseTrue;
    logic condValid;

    // Even code of each pair; the odd code is its negation
    always_comb begin : condTable
        condValid = 1'b1;
        case (cond)
            Eq, Ne: baseTrue = flags.z;
            Hs, Lo: baseTrue = flags.c;
            Mi, Pl: baseTrue = flags.n;
            Vs, Vc: baseTrue = flags.v;
            Hi, Ls: baseTrue = flags.c & ~flags.z;
            Ge, Lt: baseTrue = (flags.n == flags.v);
            Gt, Le: baseTrue = ~flags.z & (flags.n == flags.v);
            default: begin                      // 14 and 15 never taken
                baseTrue  = 1'b0;
                condValid = 1'b0;
            end
        endcase
    end

    assign branchTaken = branchEn & condValid & (baseTrue ^ cond[0]);

endmodule

/* hw/execStage.sv */
module execStage
    import execPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  execCtrlT ctrl,
    input  regDataT  regData,
    input  dataT     memDataIn,
    output regReadT  regRd,
    output regWriteT regWr,
    output memReqT   memReq,
    output flagsT    flags,
    output logic     branchTaken
);

    unitSelT unitSel;
    dataT    aluResult;
    logic    aluWrite;
    dataT    moveResult;
    logic    moveWrite;

    // Class decode, register ports, memory and write-back
    execControl uControl (
        .ctrl       (ctrl),
        .regData    (regData),
        .memDataIn  (memDataIn),
        .aluResult  (aluResult),
        .moveResult (moveResult),
        .aluWrite   (aluWrite),
        .moveWrite  (moveWrite),
        .unitSel    (unitSel),
        .regRd      (regRd),
        .regWr      (regWr),
        .memReq     (memReq)
    );

    aluUnit uAlu (
        .clk       (clk),
        .rst       (rst),
        .ctrl      (ctrl),
        .regData   (regData),
        .unitSel   (unitSel),
        .aluResult (aluResult),
        .aluWrite  (aluWrite),
        .flags     (flags)          // Registered NZCV
    );

    moveUnit uMove (
        .ctrl       (ctrl),
        .regData    (regData),
        .flags      (flags),
        .moveResult (moveResult),
        .moveWrite  (moveWrite)
    );

    branchCond uBranch (
        .cond        (ctrl.cond),
        .branchEn    (unitSel.branchEn),
        .flags       (flags),
        .branchTaken (branchTaken)
    );

endmodule

/* verification/execStage_chk.sv */
module execStage_chk
    import execPkg::*;
(
    input logic     clk,
    input logic     rst,
    input execCtrlT ctrl,
    input regDataT  regData,
    input dataT     memDataIn,
    input regReadT  regRd,
    input regWriteT regWr,
    input memReqT   memReq,
    input flagsT    flags,
    input logic     branchTaken
);
    timeunit 1ns;
    timeprecision 1ps;

    int    failCount = 0;
    flagsT expFlags;

    function automatic dataT sext(input immT v);
        return {{16{v[15]}}, v};
    endfunction

    function automatic logic isAlu(input execCtrlT c);
        return c.opClass == ClassReg || (c.opClass == ClassImm && c.special);
    endfunction

    function automatic logic isMove(input execCtrlT c);
        return c.opClass == ClassImm && !c.special;
    endfunction

    function automatic logic isIdle(input execCtrlT c);
        return c.opClass == ClassImm && c.special && c.aluOp == OpNone;
    endfunction

    function automatic logic aluWrites(input execCtrlT c);
        return c.aluOp inside {OpAdd, OpSub, OpAnd, OpOr, OpXor, OpNot,
                               OpAdds, OpSubs, OpAnds, OpOrs, OpXors};
    endfunction

    function automatic dataT operandB(input execCtrlT c, input regDataT d);
        return (c.opClass == ClassImm) ? sext(c.imm) : d.sec;
    endfunction

    function automatic dataT aluRes(input execCtrlT c, input regDataT d);
        dataT b;
        b = operandB(c, d);
        case (c.aluOp)
            OpAdd, OpAdds: return d.first + b;
            OpSub, OpSubs: return d.first - b;
            OpAnd, OpAnds: return d.first & b;
            OpOr, OpOrs:   return d.first | b;
            OpXor, OpXors: return d.first ^ b;
            OpNot:         return ~d.first;
            default:       return '0;
        endcase
    endfunction

    // Flags as they must read one cycle after this instruction
    function automatic flagsT nextFlags(input execCtrlT c, input regDataT d, input flagsT f);
        dataT        a;
        dataT        b;
        dataT        r;
        logic        isSub;
        logic [32:0] wide;
        flagsT       nf;
        a     = d.first;
        b     = operandB(c, d);
        r     = aluRes(c, d);
        isSub = (c.aluOp == OpSubs);
        nf    = f;
        if (isAlu(c) && c.aluOp inside {OpAdds, OpSubs}) begin
            wide = isSub ? ({1'b0, a} + {1'b0, ~b} + 33'd1) : ({1'b0, a} + {1'b0, b});
            nf.n = r[31];
            nf.z = (r == '0);
            nf.c = wide[32];                      // Carry, or no borrow on SUBS
            nf.v = ((a[31] != b[31]) == isSub) && (r[31] != a[31]);
        end else if (isAlu(c) && c.aluOp inside {OpAnds, OpOrs, OpXors}) begin
            nf.n = r[31];
            nf.z = (r == '0);
        end
        return nf;
    endfunction

    function automatic dataT movRes(input execCtrlT c, input regDataT d, input flagsT f);
        case (c.func.mov)
            MovImm:   return {16'h0, c.imm};
            MovTop:   return {c.imm, d.dest[15:0]};
            MovClr:   return '0;
            MovSet:   return 32'hFFFF_FFFF;
            MovLsl:   return d.first << c.imm;
            MovLsr:   return d.first >> c.imm;
            MovFlags: return {20'h0, d.dest[31:24], f};
            default:  return '0;
        endcase
    endfunction

    function automatic logic condHolds(input condE cond, input flagsT f);
        logic t;
        case (cond[3:1])
            3'd0:    t = f.z;
            3'd1:    t = f.c;
            3'd2:    t = f.n;
            3'd3:    t = f.v;
            3'd4:    t = f.c && !f.z;
            3'd5:    t = (f.n == f.v);
            3'd6:    t = !f.z && (f.n == f.v);
            default: return 1'b0;                 // Codes 14 and 15
        endcase
        return t ^ cond[0];                       // Odd codes negate
    endfunction

    function automatic regReadT readPorts(input execCtrlT c);
        regReadT r;
        r = '0;
        if (isAlu(c) && aluWrites(c)) begin
            r.dest  = c.destReg;
            r.first = c.srcFirst;
            if (c.opClass == ClassReg && c.aluOp != OpNot) begin
                r.sec = c.srcSec;
            end
        end else if (isMove(c) && c.func.mov != 3'b111) begin
            r.dest = c.destReg;
            if (c.func.mov inside {MovLsl, MovLsr}) begin
                r.first = c.srcFirst;
            end
        end else if (c.opClass == ClassMem) begin
            r.dest  = c.destReg;
            r.first = c.srcFirst;
        end
        return r;
    endfunction

    // Reference flag register built from the update rules
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            expFlags <= '0;
        end else begin
            expFlags <= nextFlags(ctrl, regData, expFlags);
        end
    end

    aResetFlags: assert property (@(posedge clk) (rst || $past(rst)) |-> flags == '0)
        else begin
            failCount++;
            $error("ERROR flags got %h expected 0 around reset", flags);
        end

    aIdle: assert property (@(posedge clk) isIdle(ctrl) |->
            !regWr.en && !memReq.read && !memReq.write && !branchTaken)
        else begin
            failCount++;
            $error("ERROR idle regWr.en %h memReq.read %h memReq.write %h branchTaken %h",
                   regWr.en, memReq.read, memReq.write, branchTaken);
        end

    aReadPorts: assert property (@(posedge clk) disable iff (rst) regRd == readPorts(ctrl))
        else begin
            failCount++;
            $error("ERROR regRd got %h expected %h", regRd, readPorts(ctrl));
        end

    aAluWrite: assert property (@(posedge clk) disable iff (rst) isAlu(ctrl) |->
            regWr.en == aluWrites(ctrl) && (!regWr.en || regWr.data == aluRes(ctrl, regData)))
        else begin
            failCount++;
            $error("ERROR regWr.data got %h en %h expected %h", regWr.data, regWr.en,
                   aluRes(ctrl, regData));
        end

    aMoveWrite: assert property (@(posedge clk) disable iff (rst) isMove(ctrl) |->
            regWr.en == (ctrl.func.mov != 3'b111) &&
            (!regWr.en || regWr.data == movRes(ctrl, regData, flags)))
        else begin
            failCount++;
            $error("ERROR regWr.data got %h en %h expected %h", regWr.data, regWr.en,
                   movRes(ctrl, regData, flags));
        end

    aMemReq: assert property (@(posedge clk) disable iff (rst) ctrl.opClass == ClassMem |->
            memReq.addr == regData.first + sext(ctrl.imm) &&
            memReq.write == ctrl.func.mem.store && memReq.read == !ctrl.func.mem.store &&
            (ctrl.func.mem.store ? (memReq.wdata == regData.dest && !regWr.en)
                                 : (regWr.en && regWr.data == memDataIn)))
        else begin
            failCount++;
            $error("ERROR memReq.addr %h wdata %h regWr.data %h expected addr %h",
                   memReq.addr, memReq.wdata, regWr.data, regData.first + sext(ctrl.imm));
        end

    aFlags: assert property (@(posedge clk) disable iff (rst) flags == expFlags)
        else begin
            failCount++;
            $error("ERROR flags got %h expected %h", flags, expFlags);
        end

    aBranch: assert property (@(posedge clk) disable iff (rst)
            branchTaken == (ctrl.opClass == ClassBranch && condHolds(ctrl.cond, flags)))
        else begin
            failCount++;
            $error("ERROR branchTaken got %h for cond %h flags %h", branchTaken, ctrl.cond,
                   flags);
        end

endmodule

bind execStage execStage_chk uChk (.*);

/* verification/execStage_tb.sv */
module execStage_tb
    import execPkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ResetCycles = 8;
    localparam int AluOps      = 60;
    localparam int FlagOps     = 60;
    localparam int MoveOps     = 13;
    localparam int MemOps      = 36;
    localparam int BranchOps   = 120;
    localparam int NumTests    = 6;
    localparam int TotalOps    = ResetCycles + AluOps + FlagOps + MoveOps + MemOps
                                 + BranchOps + 2 * NumTests;

    logic     clk;
    logic     rst;
    execCtrlT ctrl;
    regDataT  regData;
    dataT     memDataIn;
    regReadT  regRd;
    regWriteT regWr;
    memReqT   memReq;
    flagsT    flags;
    logic     branchTaken;

    dataT regs [16];
    dataT mem [256];
    int   errCount   = 0;
    int   lastErrors = 0;
    int   testsRun   = 0;
    int   testsBad   = 0;

    execStage DUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Register file and memory answer in the same cycle
    assign regData.dest  = regs[ctrl.destReg];
    assign regData.first = regs[ctrl.srcFirst];
    assign regData.sec   = regs[ctrl.srcSec];
    assign memDataIn     = mem[memReq.addr[9:2]];

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= $urandom;
            end
        end else if (regWr.en) begin
            regs[regRd.dest] <= regWr.data;      // Write address is the dest port
        end
    end

    always @(posedge clk) begin
        if (memReq.write) begin
            mem[memReq.addr[9:2]] <= memReq.wdata;
        end
    end

    function automatic int totalErrors();
        return errCount + DUT.uChk.failCount;
    endfunction

    function automatic execCtrlT idleCtrl();
        execCtrlT c;
        c         = '0;
        c.opClass = ClassImm;
        c.special = 1'b1;
        c.aluOp   = OpNone;
        return c;
    endfunction

    task automatic issue(input execCtrlT c);
        @(negedge clk);
        ctrl = c;
    endtask

    task automatic checkWord(input string name, input dataT got, input dataT exp);
        if (got !== exp) begin
            errCount++;
            $display("ERROR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic closeTest(input string name);
        int n;
        issue(idleCtrl());
        issue(idleCtrl());                      // Lets the flag check of the last op run
        n          = totalErrors() - lastErrors;
        lastErrors = totalErrors();
        testsRun++;
        if (n == 0) begin
            $display("[%s] ok", name);
        end else begin
            testsBad++;
            $display("[%s] %0d errors", name, n);
        end
    endtask

    // MOV then MOVT, value is readable after the idle cycle
    task automatic loadConst(input regAddrT r, input dataT value);
        execCtrlT c;
        c         = '0;
        c.destReg = r;
        c.func.mov = MovImm;
        c.imm     = value[15:0];
        issue(c);
        c.func.mov = MovTop;
        c.imm     = value[31:16];
        issue(c);
        issue(idleCtrl());
    endtask

    task automatic randomAlu(input int count, input logic setting);
        execCtrlT c;
        int       idx;
        int       op;
        for (int k = 0; k < count; k++) begin
            if (setting) begin
                idx = $urandom_range(0, 10);
                op  = (idx < 6) ? idx + 1 : idx + 3;   // Mix of setting and plain ops
            end else begin
                op = $urandom_range(0, 6);
            end
            c          = '0;
            c.opClass  = ($urandom_range(0, 1) == 0) ? ClassImm : ClassReg;
            c.special  = 1'b1;
            c.aluOp    = aluOpE'(4'(op));
            c.imm      = 16'($urandom);
            c.destReg  = 4'($urandom);
            c.srcFirst = 4'($urandom);
            c.srcSec   = 4'($urandom);
            issue(c);
        end
    endtask

    task automatic moveTest();
        execCtrlT c;
        loadConst(4'd3, 32'hA5C3_0F1E);
        checkWord("regs[3]", regs[3], 32'hA5C3_0F1E);
        for (int k = 0; k < 8; k++) begin
            c          = '0;
            c.func.mov = movOpE'(3'(k));
            if (c.func.mov inside {MovLsl, MovLsr}) begin
                c.imm = 16'($urandom_range(1, 31));   // Count within the word
            end else begin
                c.imm = 16'($urandom) | 16'h8000;     // Top bit set shows zero extension
            end
            c.destReg  = 4'd4;
            c.srcFirst = 4'd3;
            issue(c);
        end
        c          = '0;
        c.special  = 1'b1;
        c.aluOp    = OpAdds;
        c.imm      = 16'h8001;
        c.destReg  = 4'd5;
        c.srcFirst = 4'd3;
        issue(c);
        c          = '0;
        c.func.mov = MovFlags;                   // Sees the flags from the ADDS
        c.destReg  = 4'd3;
        issue(c);
    endtask

    task automatic memTest();
        execCtrlT c;
        dataT     base;
        dataT     data;
        dataT     addr;
        for (int k = 0; k < 4; k++) begin
            base = $urandom;
            data = $urandom;
            loadConst(4'd5, base);
            loadConst(4'd6, data);
            c                = '0;
            c.opClass        = ClassMem;
            c.func.mem.store = 1'b1;
            c.imm            = 16'($urandom);
            c.destReg        = 4'd6;             // Store data
            c.srcFirst       = 4'd5;
            addr             = base + {{16{c.imm[15]}}, c.imm};
            issue(c);
            c.func.mem.store = 1'b0;
            c.destReg        = 4'd7;             // Load target
            issue(c);
            issue(idleCtrl());
            checkWord("mem word", mem[addr[9:2]], data);
            checkWord("regs[7]", regs[7], data);
        end
    endtask

    task automatic branchSweep(input dataT a, input immT imm, input aluOpE op);
        execCtrlT c;
        loadConst(4'd1, a);
        c          = '0;
        c.special  = 1'b1;
        c.aluOp    = op;
        c.imm      = imm;
        c.destReg  = 4'd2;
        c.srcFirst = 4'd1;
        issue(c);
        for (int k = 0; k < 16; k++) begin
            c         = '0;
            c.opClass = ClassBranch;
            c.cond    = condE'(4'(k));
            issue(c);
        end
    endtask

    initial begin
        void'($urandom(32'h802c));
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'hC0DE_0000 ^ 32'(i << 2);
        end
        ctrl = idleCtrl();
        rst  = 1'b1;
        repeat (ResetCycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        closeTest("reset");
        randomAlu(AluOps, 1'b0);
        closeTest("alu");
        randomAlu(FlagOps, 1'b1);
        closeTest("flags");
        moveTest();
        closeTest("move");
        memTest();
        closeTest("memory");
        branchSweep(32'h0000_0000, 16'h0000, OpSubs);    // Z C
        branchSweep(32'h0000_0001, 16'h0002, OpSubs);    // N
        branchSweep(32'h7FFF_FFFF, 16'h0001, OpAdds);    // N V
        branchSweep(32'h8000_0000, 16'hFFFF, OpAdds);    // C V
        branchSweep(32'h0000_0005, 16'h0003, OpSubs);    // C only
        branchSweep(32'h0000_0003, 16'h0004, OpAdds);    // All clear
        closeTest("branch");
        $display("tests run %0d, with errors %0d, errors %0d", testsRun, testsBad,
                 totalErrors());
        if (totalErrors() == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        #(2 * TotalOps * 10);
        $display("watchdog expired before the tests finished");
        $display("test failed");
        $finish;
    end

endmodule

/* sim.f */
common/execPkg.sv
hw/execControl.sv
alu/aluUnit.sv
hw/moveUnit.sv
hw/branchCond.sv
hw/execStage.sv
verification/execStage_chk.sv
verification/execStage_tb.sv

/* run.sh */
#!/bin/sh
# Builds the execute stage testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    -f sim.f --top-module execStage_tb -Mdir obj_dir > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "Verilator build exited with status $status"
    exit 1
fi

./obj_dir/VexecStage_tb +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "test failed" sim.log; then
    exit 1
fi
if ! grep -q "test passed" sim.log; then
    echo "no result line found in sim.log"
    exit 1
fi
exit 0
